// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module gateway_tb \
		-Mdir obj_dir -o gateway_tb

run: build
	@out="$$(./obj_dir/gateway_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module gateway_top

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+.
gw_pkg.sv
tag_trace_rom.sv
tag_trace_replay.sv
tag_master.sv
gateway_top.sv
gateway_tb.sv

// File: gateway_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "gw_config.svh"

module gateway_tb;
  import gw_pkg::*;

  localparam int CLK_HALF   = 4;
  localparam int N_EXT      = 48;
  localparam int BOOT_SENDS = 8;
  localparam int BOOT_WAIT  = 5;

  typedef tag_line_s [`GW_NUM_CLIENTS-1:0] bank_t;

  logic         clk_i;
  logic         rst_n_i;
  logic         ext_valid_i;
  trace_entry_s ext_entry_i;
  logic         ext_ready_o;
  logic         tag_data_o;
  logic         tag_en_o;
  logic         done_o;
  bank_t        clients_o;

  trace_entry_s ext_q [N_EXT];
  bank_t        model;
  logic [15:0]  lfsr;
  int           errors;
  int           limit_cycles;
  int           wait_sum;
  int           bursts;
  int           burst_len;
  logic         en_prev;
  int           accepted;
  int           sends_accepted;
  logic         check_pending;
  tag_op_e      last_op;

  gateway_top DUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ext_valid_i (ext_valid_i),
    .ext_entry_i (ext_entry_i),
    .ext_ready_o (ext_ready_o),
    .tag_data_o  (tag_data_o),
    .tag_en_o    (tag_en_o),
    .done_o      (done_o),
    .clients_o   (clients_o)
  );

  always #CLK_HALF clk_i = ~clk_i;

  //////////////////////////////
  // Helpers and reference
  //////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v = {v[14:0], lfsr[0]};
    end
  endtask

  // Only SEND touches the bank since DONE from outside counts as a NOP
  function automatic bank_t model_apply(input bank_t bank, input trace_entry_s e);
    bank_t b;
    b = bank;
    if (e.op == OP_SEND)
    begin
      if (e.data_not_reset)
      begin
        b[e.client] = '{reset: 1'b0, data: e.payload};
      end
      else
      begin
        b[e.client] = '{reset: 1'b1, data: '0};
      end
    end
    return b;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic check_clients(input string what);
    for (int c = 0; c < `GW_NUM_CLIENTS; c++)
    begin
      if (clients_o[c] !== model[c])
      begin
        report_mismatch($sformatf("%s, client %0d is reset=%b data=%h, expected reset=%b data=%h",
                                  what, c, clients_o[c].reset, clients_o[c].data,
                                  model[c].reset, model[c].data));
      end
    end
  endtask

  task automatic build_stimulus();
    logic [15:0]  v;
    trace_entry_s e;
    wait_sum = BOOT_WAIT;
    for (int i = 0; i < N_EXT; i++)
    begin
      draw_bits(2, v);
      e.op = tag_op_e'(v[1:0]);
      draw_bits(2, v);
      e.client = v[1:0];
      draw_bits(1, v);
      e.data_not_reset = v[0];
      // Short idle counts keep the run brief
      if (e.op == OP_WAIT)
      begin
        draw_bits(3, v);
        wait_sum += int'(v);
      end
      else
      begin
        draw_bits(16, v);
      end
      e.payload = v;
      ext_q[i] = e;
    end
    limit_cycles = 3 + (`GW_ROM_ENTRIES + N_EXT) * 30 + wait_sum;
  endtask

  //////////////////////////////
  // Monitors
  //////////////////////////////

  // Serial bursts at the pads
  always @(negedge clk_i)
  begin
    if (tag_en_o === 1'b1)
    begin
      if (!en_prev)
      begin
        bursts++;
        burst_len = 0;
        if (tag_data_o !== 1'b1)
        begin
          report_mismatch("first enabled bit of a packet is not a start bit");
        end
      end
      burst_len++;
    end
    else if (en_prev && burst_len != `GW_PKT_BITS)
    begin
      report_mismatch($sformatf("packet had %0d enabled cycles, expected %0d",
                                burst_len, `GW_PKT_BITS));
    end
    en_prev = (tag_en_o === 1'b1);
  end

  // Transfers and client line comparison
  always @(negedge clk_i)
  begin
    if (check_pending && ext_ready_o === 1'b1)
    begin
      check_clients($sformatf("after external %s", last_op.name()));
      check_pending = 1'b0;
    end
    if (ext_valid_i && ext_ready_o === 1'b1)
    begin
      model = model_apply(model, ext_entry_i);
      last_op = ext_entry_i.op;
      accepted++;
      if (ext_entry_i.op == OP_SEND)
      begin
        sends_accepted++;
      end
      check_pending = 1'b1;
    end
  end

  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Timeout: done_o or ext_ready_o did not arrive within %0d cycles", limit_cycles);
    $display("Errors: %0d", errors);
    $display("** FAIL **");
    $finish;
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    trace_entry_s e;
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    ext_valid_i    = 1'b0;
    ext_entry_i    = '0;
    lfsr           = 16'd15;
    errors         = 0;
    limit_cycles   = 0;
    bursts         = 0;
    burst_len      = 0;
    en_prev        = 1'b0;
    accepted       = 0;
    sends_accepted = 0;
    check_pending  = 1'b0;
    last_op        = OP_NOP;
    build_stimulus();
    for (int c = 0; c < `GW_NUM_CLIENTS; c++)
    begin
      model[c] = '{reset: 1'b1, data: '0};
    end

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_clients("in reset");
    if (done_o !== 1'b0 || tag_en_o !== 1'b0 || tag_data_o !== 1'b0 || ext_ready_o !== 1'b0)
    begin
      report_mismatch("done_o, tag_en_o, tag_data_o or ext_ready_o not low in reset");
    end
    @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Boot trace
    @(negedge clk_i);
    while (done_o !== 1'b1)
    begin
      @(negedge clk_i);
    end
    for (int c = 0; c < `GW_NUM_CLIENTS; c++)
    begin
      e = '{op: OP_SEND, client: 2'(c), data_not_reset: 1'b0, payload: '0};
      model = model_apply(model, e);
      e = '{op: OP_SEND, client: 2'(c), data_not_reset: 1'b1,
            payload: 16'(16'h1111 * (c + 1))};
      model = model_apply(model, e);
    end
    check_clients("after boot trace");
    if (bursts != BOOT_SENDS)
    begin
      report_mismatch($sformatf("boot trace sent %0d packets, expected %0d", bursts, BOOT_SENDS));
    end

    // External entries with valid held high through busy periods
    @(posedge clk_i);
    for (int i = 0; i < N_EXT; i++)
    begin
      ext_valid_i <= 1'b1;
      ext_entry_i <= ext_q[i];
      @(negedge clk_i);
      while (ext_ready_o !== 1'b1)
      begin
        @(negedge clk_i);
      end
      @(posedge clk_i);
    end
    ext_valid_i <= 1'b0;
    @(negedge clk_i);
    while (ext_ready_o !== 1'b1 || check_pending)
    begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);

    if (bursts != BOOT_SENDS + sends_accepted)
    begin
      report_mismatch($sformatf("%0d packets for %0d accepted external SEND entries",
                                bursts - BOOT_SENDS, sends_accepted));
    end
    $display("Errors: %0d, entries accepted: %0d, packets: %0d", errors, accepted, bursts);
    if (errors == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: gateway_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "gw_config.svh"

module gateway_top (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   ext_valid_i,
  input  gw_pkg::trace_entry_s                   ext_entry_i,
  output logic                                   ext_ready_o,
  output logic                                   tag_data_o,
  output logic                                   tag_en_o,
  output logic                                   done_o,
  output gw_pkg::tag_line_s [`GW_NUM_CLIENTS-1:0] clients_o
);
  import gw_pkg::*;

  rom_addr_t    rom_addr_lo;
  trace_entry_s rom_entry_lo;
  logic         tag_data_lo;
  logic         tag_en_lo;

  //////////////////////////////
  // Trace replay
  //////////////////////////////

  tag_trace_rom u_rom (
    .addr_i  (rom_addr_lo),
    .entry_o (rom_entry_lo)
  );

  tag_trace_replay u_replay (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rom_addr_o  (rom_addr_lo),
    .rom_entry_i (rom_entry_lo),
    .ext_valid_i (ext_valid_i),
    .ext_entry_i (ext_entry_i),
    .ext_ready_o (ext_ready_o),
    .tag_data_o  (tag_data_lo),
    .tag_en_o    (tag_en_lo),
    .done_o      (done_o)
  );

  // Serial tag lines out to the pads
  assign tag_data_o = tag_data_lo;
  assign tag_en_o   = tag_en_lo;

  //////////////////////////////
  // Tag master
  //////////////////////////////

  tag_master u_master (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .tag_data_i (tag_data_lo),
    .tag_en_i   (tag_en_lo),
    .clients_o  (clients_o)
  );

endmodule

`default_nettype wire

// File: gw_config.svh
`ifndef GW_CONFIG_SVH
`define GW_CONFIG_SVH

// Configuration clients on the tag master
`define GW_NUM_CLIENTS 4
`define GW_CLIENT_W    2

// Tag payload and WAIT counter
`define GW_PAYLOAD_W   16
`define GW_WAIT_W      `GW_PAYLOAD_W

// Boot trace ROM
`define GW_ROM_ENTRIES 9
`define GW_ROM_ADDR_W  4

// Start bit, client id, data_not_reset, payload
`define GW_PKT_BITS    (1 + `GW_CLIENT_W + 1 + `GW_PAYLOAD_W)

`endif

// File: gw_pkg.sv
`default_nettype none

`include "gw_config.svh"

package gw_pkg;

  // Trace opcodes
  typedef enum logic [1:0]
  {
    OP_NOP  = 2'd0,
    OP_SEND = 2'd1,
    OP_WAIT = 2'd2,
    OP_DONE = 2'd3
  } tag_op_e;

  typedef logic [`GW_ROM_ADDR_W-1:0] rom_addr_t;

  // One trace entry, payload is the idle count for OP_WAIT
  typedef struct packed
  {
    tag_op_e                  op;
    logic [`GW_CLIENT_W-1:0]  client;
    logic                     data_not_reset;
    logic [`GW_PAYLOAD_W-1:0] payload;
  } trace_entry_s;

  // Per-client configuration line
  typedef struct packed
  {
    logic                     reset;
    logic [`GW_PAYLOAD_W-1:0] data;
  } tag_line_s;

  typedef enum logic [1:0]
  {
    S_FETCH,
    S_SHIFT,
    S_WAIT,
    S_EXT
  } replay_state_e;

  typedef enum logic
  {
    M_IDLE,
    M_SHIFT
  } master_state_e;

endpackage

`default_nettype wire

// File: tag_master.sv
`timescale 1ns/1ns
`default_nettype none

`include "gw_config.svh"

module tag_master (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   tag_data_i,
  input  logic                                   tag_en_i,
  output gw_pkg::tag_line_s [`GW_NUM_CLIENTS-1:0] clients_o
);
  import gw_pkg::*;

  master_state_e                    state_r;
  logic [`GW_PKT_BITS-3:0]          shift_r;
  logic [$clog2(`GW_PKT_BITS)-1:0]  cnt_r;
  tag_line_s [`GW_NUM_CLIENTS-1:0]  clients_r;

  logic [`GW_PKT_BITS-2:0]          pkt_w;
  logic [`GW_CLIENT_W-1:0]          client_w;
  logic                             dnr_w;
  logic [`GW_PAYLOAD_W-1:0]         payload_w;
  logic                             last_w;

  //////////////////////////////
  // Packet decode
  //////////////////////////////

  // Last bit joins the stored ones, first received in bit 0
  assign pkt_w     = {tag_data_i, shift_r};
  assign client_w  = pkt_w[`GW_CLIENT_W-1:0];
  assign dnr_w     = pkt_w[`GW_CLIENT_W];
  assign payload_w = pkt_w[`GW_PKT_BITS-2 -: `GW_PAYLOAD_W];

  assign last_w = (state_r == M_SHIFT) && tag_en_i && (cnt_r == `GW_PKT_BITS - 2);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= M_IDLE;
      cnt_r   <= '0;
    end
    else
    begin
      case (state_r)
        M_IDLE:
        begin
          // Wait for start bit
          if (tag_en_i && tag_data_i)
          begin
            state_r <= M_SHIFT;
            cnt_r   <= '0;
          end
        end
        M_SHIFT:
        begin
          if (last_w)
          begin
            state_r <= M_IDLE;
          end
          else if (tag_en_i)
          begin
            cnt_r <= cnt_r + 1'b1;
          end
        end
        default:
        begin
          state_r <= M_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (state_r == M_SHIFT && tag_en_i)
    begin
      shift_r <= {tag_data_i, shift_r[`GW_PKT_BITS-3:1]};
    end
  end

  //////////////////////////////
  // Client line bank
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < `GW_NUM_CLIENTS; i++)
      begin
        clients_r[i] <= '{reset: 1'b1, data: '0};
      end
    end
    else if (last_w)
    begin
      if (dnr_w)
      begin
        clients_r[client_w] <= '{reset: 1'b0, data: payload_w};
      end
      else
      begin
        clients_r[client_w] <= '{reset: 1'b1, data: '0};
      end
    end
  end

  assign clients_o = clients_r;

endmodule

`default_nettype wire

// File: tag_trace_replay.sv
`timescale 1ns/1ns
`default_nettype none

`include "gw_config.svh"

module tag_trace_replay (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  output gw_pkg::rom_addr_t    rom_addr_o,
  input  gw_pkg::trace_entry_s rom_entry_i,
  input  logic                 ext_valid_i,
  input  gw_pkg::trace_entry_s ext_entry_i,
  output logic                 ext_ready_o,
  output logic                 tag_data_o,
  output logic                 tag_en_o,
  output logic                 done_o
);
  import gw_pkg::*;

  replay_state_e                   state_r;
  rom_addr_t                       addr_r;
  logic [`GW_PKT_BITS-2:0]         shift_r;
  logic [$clog2(`GW_PKT_BITS)-1:0] bit_cnt_r;
  logic [`GW_WAIT_W-1:0]           wait_cnt_r;
  logic                            done_r;
  logic                            tag_en_r;
  logic                            tag_data_r;

  trace_entry_s                    entry_w;
  logic                            take_w;
  logic [`GW_PKT_BITS-1:0]         pkt_w;
  replay_state_e                   home_w;

  //////////////////////////////
  // Entry selection
  //////////////////////////////

  // ROM before done, external port after
  assign entry_w = (state_r == S_EXT) ? ext_entry_i : rom_entry_i;

  assign ext_ready_o = done_r && (state_r == S_EXT);
  assign take_w      = (state_r == S_FETCH) || (ext_ready_o && ext_valid_i);

  // Sent LSB first, start bit in bit 0
  assign pkt_w = {entry_w.payload, entry_w.data_not_reset, entry_w.client, 1'b1};

  // Where to go once a SEND or WAIT finishes
  assign home_w = done_r ? S_EXT : S_FETCH;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r    <= S_FETCH;
      addr_r     <= '0;
      bit_cnt_r  <= '0;
      wait_cnt_r <= '0;
      done_r     <= 1'b0;
      tag_en_r   <= 1'b0;
      tag_data_r <= 1'b0;
    end
    else
    begin
      case (state_r)
        S_FETCH, S_EXT:
        begin
          if (state_r == S_FETCH && rom_entry_i.op != OP_DONE)
          begin
            addr_r <= addr_r + 1'b1;
          end
          if (take_w)
          begin
            case (entry_w.op)
              OP_SEND:
              begin
                // Start bit goes out on this edge
                tag_en_r   <= 1'b1;
                tag_data_r <= pkt_w[0];
                bit_cnt_r  <= '0;
                state_r    <= S_SHIFT;
              end
              OP_WAIT:
              begin
                wait_cnt_r <= entry_w.payload;
                if (entry_w.payload != '0)
                begin
                  state_r <= S_WAIT;
                end
              end
              OP_DONE:
              begin
                // Also a plain NOP once already in S_EXT
                done_r  <= 1'b1;
                state_r <= S_EXT;
              end
              default:
              begin
                state_r <= state_r;
              end
            endcase
          end
        end

        S_SHIFT:
        begin
          if (bit_cnt_r == `GW_PKT_BITS - 1)
          begin
            tag_en_r   <= 1'b0;
            tag_data_r <= 1'b0;
            state_r    <= home_w;
          end
          else
          begin
            tag_data_r <= shift_r[0];
            bit_cnt_r  <= bit_cnt_r + 1'b1;
          end
        end

        S_WAIT:
        begin
          if (wait_cnt_r <= 1)
          begin
            state_r <= home_w;
          end
          else
          begin
            wait_cnt_r <= wait_cnt_r - 1'b1;
          end
        end

        default:
        begin
          state_r <= S_FETCH;
        end
      endcase
    end
  end

  // Bits still to send after the start bit
  always_ff @(posedge clk_i)
  begin
    if ((state_r == S_FETCH || state_r == S_EXT) && take_w && entry_w.op == OP_SEND)
    begin
      shift_r <= pkt_w[`GW_PKT_BITS-1:1];
    end
    else if (state_r == S_SHIFT)
    begin
      shift_r <= shift_r >> 1;
    end
  end

  assign rom_addr_o = addr_r;
  assign tag_en_o   = tag_en_r;
  assign tag_data_o = tag_data_r;
  assign done_o     = done_r;

endmodule

`default_nettype wire

// File: tag_trace_rom.sv
`timescale 1ns/1ns
`default_nettype none

`include "gw_config.svh"

module tag_trace_rom (
  input  gw_pkg::rom_addr_t    addr_i,
  output gw_pkg::trace_entry_s entry_o
);
  import gw_pkg::*;

  function automatic trace_entry_s make_entry(
    input tag_op_e                  op,
    input logic [`GW_CLIENT_W-1:0]  client,
    input logic                     dnr,
    input logic [`GW_PAYLOAD_W-1:0] payload
  );
    return '{op: op, client: client, data_not_reset: dnr, payload: payload};
  endfunction

  //////////////////////////////
  // Boot trace
  //////////////////////////////

  always_comb
  begin
    case (addr_i)
      // Put every client into reset
      rom_addr_t'(0): entry_o = make_entry(OP_SEND, 2'd0, 1'b0, 16'h0000);
      rom_addr_t'(1): entry_o = make_entry(OP_SEND, 2'd1, 1'b0, 16'h0000);
      rom_addr_t'(2): entry_o = make_entry(OP_SEND, 2'd2, 1'b0, 16'h0000);
      rom_addr_t'(3): entry_o = make_entry(OP_SEND, 2'd3, 1'b0, 16'h0000);
      // Let the clients settle
      rom_addr_t'(4): entry_o = make_entry(OP_WAIT, 2'd0, 1'b0, 16'd5);
      // Release with initial values
      rom_addr_t'(5): entry_o = make_entry(OP_SEND, 2'd0, 1'b1, 16'h1111);
      rom_addr_t'(6): entry_o = make_entry(OP_SEND, 2'd1, 1'b1, 16'h2222);
      rom_addr_t'(7): entry_o = make_entry(OP_SEND, 2'd2, 1'b1, 16'h3333);
      rom_addr_t'(8): entry_o = make_entry(OP_SEND, 2'd3, 1'b1, 16'h4444);
      default:        entry_o = make_entry(OP_DONE, '0, 1'b0, '0);
    endcase
  end

endmodule

`default_nettype wire
